/* rv_testdata.txt */
# I <instruction word> | S <store address> <store data> | H <E=ebreak T=trap> <final PC>
# Each H line closes a program section; the next section runs after a reset
I 00500093 addi x1,x0,5
I FFD00113 addi x2,x0,-3
I 002081B3 add x3,x1,x2
I 00302023 sw x3,0
I 40208233 sub x4,x1,x2
I 00402223 sw x4,4
I 001122B3 slt x5,x2,x1
I 00113333 sltu x6,x2,x1
I 00502423 sw x5,8
I 00602623 sw x6,12
I 0F014393 xori x7,x2,0xf0
I 4043D413 srai x8,x7,4
I 00802823 sw x8,16
I 01C3D493 srli x9,x7,28
I 00849493 slli x9,x9,8
I 0A54E493 ori x9,x9,0xa5
I 7F04F493 andi x9,x9,0x7f0
I 00902A23 sw x9,20
I 12345537 lui x10,0x12345
I 00001597 auipc x11,1
I 00A02C23 sw x10,24
I 00B02E23 sw x11,28
I 0093F633 and x12,x7,x9
I 00166633 or x12,x12,x1
I 00364633 xor x12,x12,x3
I 001616B3 sll x13,x12,x1
I 40115733 sra x14,x2,x1
I 001157B3 srl x15,x2,x1
I 00E686B3 add x13,x13,x14
I 02D02023 sw x13,32
I 02F02223 sw x15,36
I FFE12813 slti x16,x2,-2
I FFF0B893 sltiu x17,x1,-1
I 01180833 add x16,x16,x17
I 03002423 sw x16,40
I 00208463 beq not taken
I 04102023 sw x1,0x40
I 00108463 beq taken
I 06102E23 skipped
I 00109463 bne not taken
I 04102223 sw x1,0x44
I 00209463 bne taken
I 06102E23 skipped
I 0020C463 blt not taken
I 04102423 sw x1,0x48
I 00114463 blt taken
I 06102E23 skipped
I 00115463 bge not taken
I 04102623 sw x1,0x4c
I 0020D463 bge taken
I 06102E23 skipped
I 0020E463 bltu taken
I 06102E23 skipped
I 00116463 bltu not taken
I 04102823 sw x1,0x50
I 0020F463 bgeu not taken
I 04102A23 sw x1,0x54
I 00117463 bgeu taken
I 06102E23 skipped
I 00C0096F jal x18,+12
I 06102E23 skipped
I 06102E23 skipped
I 05202C23 sw x18,0x58
I 10C00993 addi x19,x0,0x10c
I 00198A67 jalr x20,1(x19)
I 06102E23 skipped
I 06102E23 skipped
I 05402E23 sw x20,0x5c
I 00402A83 lw x21,4
I 001A8A93 addi x21,x21,1
I 07502023 sw x21,0x60
I 00708013 addi x0,x1,7
I 06002223 sw x0,0x64
I 00100073 ebreak
S 00000000 00000002
S 00000004 00000008
S 00000008 00000001
S 0000000C 00000000
S 00000010 FFFFFFF0
S 00000014 000007A0
S 00000018 12345000
S 0000001C 0000104C
S 00000020 0000E0DF
S 00000024 07FFFFFF
S 00000028 00000002
S 00000040 00000005
S 00000044 00000005
S 00000048 00000005
S 0000004C 00000005
S 00000050 00000005
S 00000054 00000005
S 00000058 000000F0
S 0000005C 00000104
S 00000060 00000009
S 00000064 00000000
H E 00000124
I 00900093 addi x1,x0,9
I 00102023 sw x1,0
I 02000033 mul, not supported
S 00000000 00000009
H T 00000008

/* flist.f */
rv_pkg.sv
rv_fetch.sv
rv_decode.sv
rv_regfile.sv
rv_execute.sv
rv_mem_wb.sv
rv_core.sv
tb_rv_core.sv

/* Bender.yml */
package:
  name: rv_core

sources:
  - rv_pkg.sv
  - rv_fetch.sv
  - rv_decode.sv
  - rv_regfile.sv
  - rv_execute.sv
  - rv_mem_wb.sv
  - rv_core.sv
  - target: simulation
    files:
      - tb_rv_core.sv

/* tb_rv_core.sv */
`timescale 1ns/10ps

module tb_rv_core;
  import rv_pkg::*;

  localparam int MEM_WORDS = 256;

  logic     clk;
  logic     rst_n;
  xlen_t    imem_raddr;
  xlen_t    imem_rdata;
  logic     dmem_ren;
  xlen_t    dmem_raddr;
  xlen_t    dmem_rdata;
  dmem_wr_t dmem_wr;
  logic     ebreak;
  logic     trap;

  xlen_t    imem [MEM_WORDS];
  xlen_t    dmem [MEM_WORDS];
  dmem_wr_t exp_stores [$];
  integer   fd;
  integer   n_words;
  integer   cycles;
  integer   limit;
  logic [7:0] halt_kind;
  xlen_t    halt_pc;
  bit       have_section;

  rv_core u_dut (
    .clk        (clk),
    .rst_n      (rst_n),
    .imem_raddr (imem_raddr),
    .imem_rdata (imem_rdata),
    .dmem_ren   (dmem_ren),
    .dmem_raddr (dmem_raddr),
    .dmem_rdata (dmem_rdata),
    .dmem_wr    (dmem_wr),
    .ebreak     (ebreak),
    .trap       (trap)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  // ----------------------------------------------------------
  // Memory models
  // ----------------------------------------------------------

  // Zero-latency reads indexed by address bits 9:2
  assign imem_rdata = imem[imem_raddr[9:2]];
  // Load data is only valid while the read enable is high
  assign dmem_rdata = dmem_ren ? dmem[dmem_raddr[9:2]] : 'x;

  always @(posedge clk) begin
    if (dmem_wr.we) begin
      dmem[dmem_wr.waddr[9:2]] <= dmem_wr.wdata;
    end
  end

  task automatic stop_run(input string why);
    $display("%s", why);
    $display("tests failed");
    $fatal(1);
  endtask

  task automatic check_store(input dmem_wr_t act, input dmem_wr_t exp);
    if (act !== exp) begin
      $display("FAIL t=%0t dmem_wr got %h expected %h", $time, act, exp);
      stop_run("store mismatch");
    end
  endtask

  task automatic check_pc(input xlen_t act, input xlen_t exp);
    if (act !== exp) begin
      $display("FAIL t=%0t pc got %h expected %h", $time, act, exp);
      stop_run("final PC mismatch");
    end
  endtask

  task automatic check_halt(input string name, input logic act, input logic exp);
    if (act !== exp) begin
      $display("FAIL t=%0t %s got %b expected %b", $time, name, act, exp);
      stop_run("halt flag mismatch");
    end
  endtask

  // Stores are sampled mid-cycle while the combinational request is stable
  always @(negedge clk) begin
    if (rst_n && dmem_wr.we) begin
      if (exp_stores.size() == 0) begin
        $display("Unexpected store to %h with data %h", dmem_wr.waddr, dmem_wr.wdata);
        stop_run("store beyond the expected list");
      end else begin
        check_store(dmem_wr, exp_stores.pop_front());
      end
    end
  end

  // ----------------------------------------------------------
  // Data file reader for one program section up to its H line
  // ----------------------------------------------------------

  task automatic load_section(output bit got);
    string    line;
    xlen_t    word;
    xlen_t    addr;
    xlen_t    data;
    dmem_wr_t rec;
    integer   n;
    got = 0;
    n_words = 0;
    for (int i = 0; i < MEM_WORDS; i++) begin
      imem[i] = '0;
    end
    while (!$feof(fd) && !got) begin
      n = $fgets(line, fd);
      if (n > 0 && line.len() > 0) begin
        case (line.getc(0))
          "I": begin
            n = $sscanf(line, "I %h", word);
            imem[n_words] = word;
            n_words++;
          end
          "S": begin
            n = $sscanf(line, "S %h %h", addr, data);
            rec.we    = 1'b1;
            rec.waddr = addr;
            rec.wdata = data;
            exp_stores.push_back(rec);
          end
          "H": begin
            n = $sscanf(line, "H %c %h", halt_kind, halt_pc);
            got = 1;
          end
          default: ;
        endcase
      end
    end
  endtask

  // ----------------------------------------------------------
  // Main sequence
  // ----------------------------------------------------------

  initial begin
    rst_n = 1'b0;
    // Fill pattern tied to every address bit of the word index
    for (int i = 0; i < MEM_WORDS; i++) begin
      dmem[i] = 32'hdead_0000 | xlen_t'(i * 4);
    end
    fd = $fopen("rv_testdata.txt", "r");
    if (fd == 0) begin
      stop_run("could not open rv_testdata.txt");
    end
    load_section(have_section);
    while (have_section) begin
      rst_n = 1'b0;
      repeat (3) @(posedge clk);
      #1 rst_n = 1'b1;
      limit  = 8 * n_words + 50;
      cycles = 0;
      // Run until the core halts
      while (!(ebreak || trap)) begin
        @(posedge clk);
        #1;
        cycles++;
        if (cycles > limit) begin
          stop_run("timeout, the core never halted");
        end
      end
      check_halt("ebreak", ebreak, halt_kind == "E");
      check_halt("trap", trap, halt_kind == "T");
      check_pc(imem_raddr, halt_pc);
      if (exp_stores.size() != 0) begin
        $display("%0d expected stores never happened", exp_stores.size());
        stop_run("halt with stores still expected");
      end
      // A frozen core makes no stores and keeps its PC
      repeat (5) @(posedge clk);
      #1;
      check_pc(imem_raddr, halt_pc);
      check_halt("ebreak", ebreak, halt_kind == "E");
      check_halt("trap", trap, halt_kind == "T");
      rst_n = 1'b0;
      load_section(have_section);
    end
    $fclose(fd);
    $display("all tests passed");
    $finish;
  end

endmodule

/* rv_core.sv */
`timescale 1ns/10ps

module rv_core (
  input  logic             clk,
  input  logic             rst_n,
  output rv_pkg::xlen_t    imem_raddr,
  input  rv_pkg::xlen_t    imem_rdata,
  output logic             dmem_ren,
  output rv_pkg::xlen_t    dmem_raddr,
  input  rv_pkg::xlen_t    dmem_rdata,
  output rv_pkg::dmem_wr_t dmem_wr,
  output logic             ebreak,
  output logic             trap
);
  import rv_pkg::*;

  xlen_t     pc_plus4;
  dec_ctrl_t ctrl;
  xlen_t     imm;
  reg_addr_t rs1;
  reg_addr_t rs2;
  reg_addr_t rd;
  logic      halt;
  xlen_t     rs1_data;
  xlen_t     rs2_data;
  xlen_t     alu_result;
  logic      redirect;
  xlen_t     target;
  logic      rd_we;
  xlen_t     rd_data;

  // ----------------------------------------------------------
  // Fetch, the PC doubles as the instruction address
  // ----------------------------------------------------------

  rv_fetch u_fetch (
    .clk      (clk),
    .rst_n    (rst_n),
    .halt     (halt),
    .redirect (redirect),
    .target   (target),
    .pc       (imem_raddr),
    .pc_plus4 (pc_plus4)
  );

  // Instruction word arrives in the same cycle
  rv_decode u_decode (
    .rst_n  (rst_n),
    .instr  (imem_rdata),
    .ctrl   (ctrl),
    .imm    (imm),
    .rs1    (rs1),
    .rs2    (rs2),
    .rd     (rd),
    .halt   (halt),
    .ebreak (ebreak),
    .trap   (trap)
  );

  rv_regfile u_regfile (
    .clk      (clk),
    .rs1      (rs1),
    .rs2      (rs2),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data),
    .we       (rd_we),
    .rd       (rd),
    .rd_data  (rd_data)
  );

  // ----------------------------------------------------------
  // Execute and memory/write-back
  // ----------------------------------------------------------

  rv_execute u_execute (
    .ctrl       (ctrl),
    .pc         (imem_raddr),
    .rs1_data   (rs1_data),
    .rs2_data   (rs2_data),
    .imm        (imm),
    .alu_result (alu_result),
    .redirect   (redirect),
    .target     (target)
  );

  rv_mem_wb u_mem_wb (
    .rst_n      (rst_n),
    .halt       (halt),
    .ctrl       (ctrl),
    .alu_result (alu_result),
    .rs2_data   (rs2_data),
    .pc_plus4   (pc_plus4),
    .dmem_rdata (dmem_rdata),
    .dmem_ren   (dmem_ren),
    .dmem_raddr (dmem_raddr),
    .dmem_wr    (dmem_wr),
    .rd_we      (rd_we),
    .rd_data    (rd_data)
  );

endmodule

/* rv_mem_wb.sv */
`timescale 1ns/10ps

module rv_mem_wb (
  input  logic              rst_n,
  input  logic              halt,
  input  rv_pkg::dec_ctrl_t ctrl,
  input  rv_pkg::xlen_t     alu_result,
  input  rv_pkg::xlen_t     rs2_data,
  input  rv_pkg::xlen_t     pc_plus4,
  input  rv_pkg::xlen_t     dmem_rdata,
  output logic              dmem_ren,
  output rv_pkg::xlen_t     dmem_raddr,
  output rv_pkg::dmem_wr_t  dmem_wr,
  output logic              rd_we,
  output rv_pkg::xlen_t     rd_data
);
  import rv_pkg::*;

  logic  commit;
  xlen_t word_addr;

  // State changes only when running and out of reset
  assign commit = rst_n && !halt;

  // Word accesses only, low address bits ignored
  assign word_addr = {alu_result[XLEN-1:2], 2'b00};

  // ----------------------------------------------------------
  // Data memory requests
  // ----------------------------------------------------------

  assign dmem_ren      = commit && ctrl.mem_read;
  assign dmem_raddr    = word_addr;
  assign dmem_wr.we    = commit && ctrl.mem_write;
  assign dmem_wr.waddr = word_addr;
  assign dmem_wr.wdata = rs2_data;

  // ----------------------------------------------------------
  // Write-back
  // ----------------------------------------------------------

  assign rd_we = commit && ctrl.reg_write;

  always_comb begin
    case (ctrl.res_src)
      RES_MEM: rd_data = dmem_rdata;
      RES_PC4: rd_data = pc_plus4;
      default: rd_data = alu_result;
    endcase
  end

  always_comb begin
    a_no_rw_overlap : assert final (!(dmem_ren && dmem_wr.we))
      else $error("data memory read and write in one cycle");
  end

endmodule

/* rv_execute.sv */
`timescale 1ns/10ps

module rv_execute (
  input  rv_pkg::dec_ctrl_t ctrl,
  input  rv_pkg::xlen_t     pc,
  input  rv_pkg::xlen_t     rs1_data,
  input  rv_pkg::xlen_t     rs2_data,
  input  rv_pkg::xlen_t     imm,
  output rv_pkg::xlen_t     alu_result,
  output logic              redirect,
  output rv_pkg::xlen_t     target
);
  import rv_pkg::*;

  xlen_t      op_a;
  xlen_t      op_b;
  logic [4:0] shamt;
  logic       eq;
  logic       lt_s;
  logic       lt_u;
  logic       taken;
  xlen_t      jalr_sum;

  // ----------------------------------------------------------
  // Operands
  // ----------------------------------------------------------

  always_comb begin
    case (ctrl.a_src)
      A_RS1:   op_a = rs1_data;
      A_PC:    op_a = pc;
      default: op_a = '0;
    endcase
  end

  assign op_b  = ctrl.b_is_imm ? imm : rs2_data;
  assign shamt = op_b[4:0];

  // Shared comparators for SLT/SLTU and branches
  assign eq   = (op_a == op_b);
  assign lt_s = ($signed(op_a) < $signed(op_b));
  assign lt_u = (op_a < op_b);

  // ----------------------------------------------------------
  // ALU
  // ----------------------------------------------------------

  always_comb begin
    case (ctrl.alu_op)
      ALU_ADD:    alu_result = op_a + op_b;
      ALU_SUB:    alu_result = op_a - op_b;
      ALU_AND:    alu_result = op_a & op_b;
      ALU_OR:     alu_result = op_a | op_b;
      ALU_XOR:    alu_result = op_a ^ op_b;
      ALU_SLT:    alu_result = {{(XLEN-1){1'b0}}, lt_s};
      ALU_SLTU:   alu_result = {{(XLEN-1){1'b0}}, lt_u};
      ALU_SLL:    alu_result = op_a << shamt;
      ALU_SRL:    alu_result = op_a >> shamt;
      ALU_SRA:    alu_result = xlen_t'($signed(op_a) >>> shamt);
      ALU_PASS_B: alu_result = op_b;
      default:    alu_result = '0;
    endcase
  end

  // ----------------------------------------------------------
  // Branch condition and target
  // ----------------------------------------------------------

  always_comb begin
    case (ctrl.funct3)
      F3_BEQ:  taken = eq;
      F3_BNE:  taken = !eq;
      F3_BLT:  taken = lt_s;
      F3_BGE:  taken = !lt_s;
      F3_BLTU: taken = lt_u;
      F3_BGEU: taken = !lt_u;
      default: taken = 1'b0;
    endcase
  end

  assign jalr_sum = rs1_data + imm;

  // JALR drops bit 0, everything else is PC relative
  assign target   = ctrl.is_jalr ? {jalr_sum[XLEN-1:1], 1'b0} : pc + imm;
  assign redirect = (ctrl.is_branch && taken) || ctrl.is_jal || ctrl.is_jalr;

endmodule

/* rv_regfile.sv */
`timescale 1ns/10ps

module rv_regfile (
  input  logic              clk,
  input  rv_pkg::reg_addr_t rs1,
  input  rv_pkg::reg_addr_t rs2,
  output rv_pkg::xlen_t     rs1_data,
  output rv_pkg::xlen_t     rs2_data,
  input  logic              we,
  input  rv_pkg::reg_addr_t rd,
  input  rv_pkg::xlen_t     rd_data
);
  import rv_pkg::*;

  // All 32 words stored, entry 0 is x0
  xlen_t regs [2**REG_AW];

  // ----------------------------------------------------------
  // Write port
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    // x0 cleared on every edge
    regs[0] <= '0;
    if (we && (rd != '0)) begin
      regs[rd] <= rd_data;
    end
  end

  // ----------------------------------------------------------
  // Asynchronous read ports
  // ----------------------------------------------------------

  assign rs1_data = regs[rs1];
  assign rs2_data = regs[rs2];

  // A value retired to x0 must never come back on either port
  a_x0_rs1 : assert property (
    @(posedge clk) (rs1 == '0) |-> (rs1_data == '0)
  ) else $error("x0 read back nonzero on rs1");

  a_x0_rs2 : assert property (
    @(posedge clk) (rs2 == '0) |-> (rs2_data == '0)
  ) else $error("x0 read back nonzero on rs2");

endmodule

/* rv_decode.sv */
`timescale 1ns/10ps

module rv_decode (
  input  logic              rst_n,
  input  rv_pkg::instr_u    instr,
  output rv_pkg::dec_ctrl_t ctrl,
  output rv_pkg::xlen_t     imm,
  output rv_pkg::reg_addr_t rs1,
  output rv_pkg::reg_addr_t rs2,
  output rv_pkg::reg_addr_t rd,
  output logic              halt,
  output logic              ebreak,
  output logic              trap
);
  import rv_pkg::*;

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       f7_zero;
  logic       f7_alt;
  xlen_t      imm_i;
  xlen_t      imm_s;
  xlen_t      imm_b;
  xlen_t      imm_u;
  xlen_t      imm_j;

  // ALU op from funct3; alt selects SUB/SRA
  function automatic alu_op_t alu_from_f3(input logic [2:0] f3, input logic alt);
    alu_op_t op;
    case (f3)
      3'b000:  op = alt ? ALU_SUB : ALU_ADD;
      3'b001:  op = ALU_SLL;
      3'b010:  op = ALU_SLT;
      3'b011:  op = ALU_SLTU;
      3'b100:  op = ALU_XOR;
      3'b101:  op = alt ? ALU_SRA : ALU_SRL;
      3'b110:  op = ALU_OR;
      default: op = ALU_AND;
    endcase
    return op;
  endfunction

  // ----------------------------------------------------------
  // Fields and immediates
  // ----------------------------------------------------------

  assign opcode  = instr.ri.opcode;
  assign funct3  = instr.ri.funct3;
  assign rs1     = instr.ri.rs1;
  assign rs2     = instr.ri.rs2;
  assign rd      = instr.ri.rd;
  assign f7_zero = (instr.ri.funct7 == 7'b0000000);
  assign f7_alt  = (instr.ri.funct7 == 7'b0100000);

  // I-type reads straight through the register view
  assign imm_i = {{20{instr.ri.funct7[6]}}, instr.ri.funct7, instr.ri.rs2};
  assign imm_s = {{21{instr.sbuj.sign}}, instr.sbuj.f30_25, instr.sbuj.f11_8, instr.sbuj.f7};
  assign imm_b = {{20{instr.sbuj.sign}}, instr.sbuj.f7, instr.sbuj.f30_25,
                  instr.sbuj.f11_8, 1'b0};
  assign imm_u = {instr.sbuj.sign, instr.sbuj.f30_25, instr.sbuj.f24_21, instr.sbuj.f20,
                  instr.sbuj.f19_12, 12'b0};
  assign imm_j = {{12{instr.sbuj.sign}}, instr.sbuj.f19_12, instr.sbuj.f20,
                  instr.sbuj.f30_25, instr.sbuj.f24_21, 1'b0};

  // ----------------------------------------------------------
  // Control bundle
  // ----------------------------------------------------------

  always_comb begin
    ctrl        = '0;
    ctrl.a_src  = A_ZERO;
    ctrl.alu_op = ALU_ADD;
    ctrl.funct3 = funct3;
    imm         = '0;
    case (opcode)
      OP_LUI: begin
        ctrl.reg_write = 1'b1;
        ctrl.b_is_imm  = 1'b1;
        ctrl.alu_op    = ALU_PASS_B;
        imm            = imm_u;
      end
      OP_AUIPC: begin
        ctrl.reg_write = 1'b1;
        ctrl.a_src     = A_PC;
        ctrl.b_is_imm  = 1'b1;
        imm            = imm_u;
      end
      OP_JAL: begin
        ctrl.reg_write = 1'b1;
        ctrl.res_src   = RES_PC4;
        ctrl.is_jal    = 1'b1;
        imm            = imm_j;
      end
      OP_JALR: begin
        ctrl.reg_write  = 1'b1;
        ctrl.res_src    = RES_PC4;
        ctrl.is_jalr    = 1'b1;
        ctrl.is_illegal = (funct3 != 3'b000);
        imm             = imm_i;
      end
      OP_BRANCH: begin
        // Compare runs rs1 against rs2 through the ALU operands
        ctrl.is_branch = 1'b1;
        ctrl.a_src     = A_RS1;
        ctrl.alu_op    = ALU_SUB;
        imm            = imm_b;
        case (funct3)
          F3_BEQ, F3_BNE, F3_BLT, F3_BGE, F3_BLTU, F3_BGEU: ctrl.is_illegal = 1'b0;
          default: ctrl.is_illegal = 1'b1;
        endcase
      end
      OP_LOAD: begin
        ctrl.reg_write  = 1'b1;
        ctrl.mem_read   = 1'b1;
        ctrl.a_src      = A_RS1;
        ctrl.b_is_imm   = 1'b1;
        ctrl.res_src    = RES_MEM;
        ctrl.is_illegal = (funct3 != F3_WORD);
        imm             = imm_i;
      end
      OP_STORE: begin
        ctrl.mem_write  = 1'b1;
        ctrl.a_src      = A_RS1;
        ctrl.b_is_imm   = 1'b1;
        ctrl.is_illegal = (funct3 != F3_WORD);
        imm             = imm_s;
      end
      OP_IMM: begin
        ctrl.reg_write = 1'b1;
        ctrl.a_src     = A_RS1;
        ctrl.b_is_imm  = 1'b1;
        imm            = imm_i;
        // Shifts reuse funct7 as a qualifier while other ops take the full imm
        if (funct3 == 3'b001) begin
          ctrl.alu_op     = ALU_SLL;
          ctrl.is_illegal = !f7_zero;
        end else if (funct3 == 3'b101) begin
          ctrl.alu_op     = alu_from_f3(funct3, f7_alt);
          ctrl.is_illegal = !(f7_zero || f7_alt);
        end else begin
          ctrl.alu_op = alu_from_f3(funct3, 1'b0);
        end
      end
      OP_RTYPE: begin
        ctrl.reg_write  = 1'b1;
        ctrl.a_src      = A_RS1;
        ctrl.alu_op     = alu_from_f3(funct3, f7_alt);
        ctrl.is_illegal = !(f7_zero || (f7_alt && (funct3 == 3'b000 || funct3 == 3'b101)));
      end
      OP_SYSTEM: begin
        ctrl.is_ebreak  = (instr == EBREAK_WORD);
        ctrl.is_illegal = (instr != EBREAK_WORD);
      end
      default: ctrl.is_illegal = 1'b1;
    endcase
  end

  // Halt flags are held low in reset
  assign ebreak = rst_n && ctrl.is_ebreak;
  assign trap   = rst_n && ctrl.is_illegal;
  assign halt   = ebreak || trap;

  always_comb begin
    a_one_halt_kind : assert final (!(ebreak && trap))
      else $error("ebreak and trap raised together");
  end

endmodule

/* rv_fetch.sv */
`timescale 1ns/10ps

module rv_fetch (
  input  logic          clk,
  input  logic          rst_n,
  input  logic          halt,
  input  logic          redirect,
  input  rv_pkg::xlen_t target,
  output rv_pkg::xlen_t pc,
  output rv_pkg::xlen_t pc_plus4
);
  import rv_pkg::*;

  // Sequential successor, also the link value for jumps
  assign pc_plus4 = pc + xlen_t'(4);

  // ----------------------------------------------------------
  // PC register
  // ----------------------------------------------------------

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      pc <= RESET_PC;
    end else if (!halt) begin
      // Taken branch or jump wins over fall-through
      pc <= redirect ? target : pc_plus4;
    end
    // Halted: keep the offending instruction in place
  end

  // Only word-sized instructions, so the fetch address stays aligned
  a_pc_aligned : assert property (
    @(posedge clk) disable iff (!rst_n) pc[1:0] == 2'b00
  ) else $error("PC not word aligned: %h", pc);

endmodule

/* rv_pkg.sv */
package rv_pkg;

  // ----------------------------------------------------------
  // Widths and reset vector
  // ----------------------------------------------------------

  localparam int XLEN   = 32;
  localparam int REG_AW = 5;

  typedef logic [XLEN-1:0]   xlen_t;
  typedef logic [REG_AW-1:0] reg_addr_t;

  // First fetch address after reset
  localparam xlen_t RESET_PC = '0;

  // ----------------------------------------------------------
  // Opcodes and function codes
  // ----------------------------------------------------------

  localparam logic [6:0] OP_LUI    = 7'b0110111;
  localparam logic [6:0] OP_AUIPC  = 7'b0010111;
  localparam logic [6:0] OP_JAL    = 7'b1101111;
  localparam logic [6:0] OP_JALR   = 7'b1100111;
  localparam logic [6:0] OP_BRANCH = 7'b1100011;
  localparam logic [6:0] OP_LOAD   = 7'b0000011;
  localparam logic [6:0] OP_STORE  = 7'b0100011;
  localparam logic [6:0] OP_IMM    = 7'b0010011;
  localparam logic [6:0] OP_RTYPE  = 7'b0110011;
  localparam logic [6:0] OP_SYSTEM = 7'b1110011;

  // The only SYSTEM encoding the core accepts
  localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;

  // Branch conditions, plus the word size code for LW/SW
  localparam logic [2:0] F3_BEQ  = 3'b000;
  localparam logic [2:0] F3_BNE  = 3'b001;
  localparam logic [2:0] F3_BLT  = 3'b100;
  localparam logic [2:0] F3_BGE  = 3'b101;
  localparam logic [2:0] F3_BLTU = 3'b110;
  localparam logic [2:0] F3_BGEU = 3'b111;
  localparam logic [2:0] F3_WORD = 3'b010;

  // ----------------------------------------------------------
  // Control encodings
  // ----------------------------------------------------------

  typedef enum logic [3:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLT, ALU_SLTU, ALU_SLL, ALU_SRL, ALU_SRA,
    ALU_PASS_B
  } alu_op_t;

  typedef enum logic [1:0] {RES_ALU, RES_MEM, RES_PC4} res_src_t;

  typedef enum logic [1:0] {A_RS1, A_PC, A_ZERO} a_src_t;

  // Register and I-immediate layout
  typedef struct packed {
    logic [6:0] funct7;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] rd;
    logic [6:0] opcode;
  } fmt_ri_t;

  // Immediate slices shared by S, B, U and J formats
  typedef struct packed {
    logic       sign;
    logic [5:0] f30_25;
    logic [3:0] f24_21;
    logic       f20;
    logic [7:0] f19_12;
    logic [3:0] f11_8;
    logic       f7;
    logic [6:0] opcode;
  } fmt_sbuj_t;

  typedef union packed {
    fmt_ri_t   ri;
    fmt_sbuj_t sbuj;
  } instr_u;

  typedef struct packed {
    logic     reg_write;
    logic     mem_read;
    logic     mem_write;
    a_src_t   a_src;
    logic     b_is_imm;
    alu_op_t  alu_op;
    res_src_t res_src;
    logic     is_branch;
    logic     is_jal;
    logic     is_jalr;
    logic     is_ebreak;
    logic     is_illegal;
    logic [2:0] funct3;
  } dec_ctrl_t;

  // Data memory write port
  typedef struct packed {
    logic  we;
    xlen_t waddr;
    xlen_t wdata;
  } dmem_wr_t;

endpackage
